// File: common/carrd_params.svh
`ifndef CARRD_PARAMS_SVH
`define CARRD_PARAMS_SVH

// datapath sizes
`define CARRD_WORD_W  32          // element and scalar width
`define CARRD_LANES   4           // elements per vector register
`define CARRD_VLEN    128         // bits per vector register
`define CARRD_NREGS   32          // v0 .. v31
`define CARRD_ADDR_W  32          // byte address toward data memory

////////////////////
// major opcodes
`define CARRD_OP_V      7'b1010111  // OP-V arith and vsetvli
`define CARRD_OP_LOAD   7'b0000111  // LOAD-FP space, vle
`define CARRD_OP_STORE  7'b0100111  // STORE-FP space, vse

// funct3 of OP-V
`define CARRD_F3_IVV    3'b000      // vector-vector
`define CARRD_F3_IVX    3'b100      // vector-scalar
`define CARRD_F3_CFG    3'b111      // vsetvli
`define CARRD_W_E32     3'b110      // width field of a 32-bit load/store
`define CARRD_MOP_UNIT  2'b00       // unit-stride mop

// funct6 of the integer ops
`define CARRD_F6_VADD   6'b000000
`define CARRD_F6_VSUB   6'b000010
`define CARRD_F6_VAND   6'b001001
`define CARRD_F6_VOR    6'b001010
`define CARRD_F6_VXOR   6'b001011

`endif

// File: common/carrd_pkg.sv
`include "carrd_params.svh"

package carrd_pkg;

    ////////////////////
    // widths with a meaning
    typedef logic [`CARRD_WORD_W-1:0] word_t;      // one element / scalar / mem word
    typedef logic [`CARRD_VLEN-1:0]   vreg_t;      // full vector register

    // register index, 5 bits for 32 regs
    typedef logic [$clog2(`CARRD_NREGS)-1:0] vaddr_t;

    typedef logic [2:0] vl_t;                      // 0 .. 4 elements
    typedef logic [`CARRD_LANES-1:0] elem_mask_t;  // per-element write enable
    typedef logic [31:0] instr_t;                  // raw RVV encoding

    ////////////////////
    // state machines and ops

    // lane operation select
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,                                   // vs2 - vs1 / vs2 - rs1
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    // load/store sequencer
    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_BEAT,                                  // one wishbone beat per element
        LSU_WB                                     // load result waiting for the write port
    } lsu_state_e;

endpackage

// File: logic/carrd_issue.sv
`timescale 1ns/100ps
`include "carrd_params.svh"

module carrd_issue
    import carrd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       instr_cyc,
    input  logic       instr_stb,
    input  instr_t     instr_dat,
    input  word_t      instr_rs1,
    output logic       instr_ack,
    output vaddr_t     rd_addr_a,
    output vaddr_t     rd_addr_b,
    input  vreg_t      rd_data_a,
    input  vreg_t      rd_data_b,
    output logic       alu_start,
    output alu_op_e    alu_op,
    output vreg_t      alu_a,
    output vreg_t      alu_b,
    output vaddr_t     alu_vd,
    input  logic       alu_busy,
    output logic       lsu_start,
    output logic       lsu_we,
    output word_t      lsu_base,
    output vl_t        lsu_vl,
    output vreg_t      lsu_data,
    output vaddr_t     lsu_vd,
    input  logic       lsu_busy,
    output elem_mask_t wb_mask_vl,
    input  logic       wb_valid,
    input  vaddr_t     wb_vd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [5:0] funct6;
    vaddr_t     f_vd, f_vs1, f_vs2;          // f_vd doubles as vs3 for stores
    alu_op_e    dec_op;
    logic       op_ok;
    logic       is_cfg, is_vx, is_alu, is_load, is_store;
    logic       hazard, unit_busy, accept;
    logic [`CARRD_NREGS-1:0] pending_q;      // write outstanding per register
    vl_t        vl_q;
    elem_mask_t mask_now;

    ////////////////////
    // decode
    assign opcode = instr_dat[6:0];
    assign f_vd   = instr_dat[11:7];
    assign funct3 = instr_dat[14:12];
    assign f_vs1  = instr_dat[19:15];
    assign f_vs2  = instr_dat[24:20];
    assign funct6 = instr_dat[31:26];       // vm bit 25 ignored

    always_comb begin
        op_ok  = 1'b1;
        dec_op = ALU_ADD;
        case (funct6)
            `CARRD_F6_VADD: dec_op = ALU_ADD;
            `CARRD_F6_VSUB: dec_op = ALU_SUB;
            `CARRD_F6_VAND: dec_op = ALU_AND;
            `CARRD_F6_VOR:  dec_op = ALU_OR;
            `CARRD_F6_VXOR: dec_op = ALU_XOR;
            default:        op_ok  = 1'b0;  // unsupported, acked and dropped
        endcase
    end

    assign is_cfg   = (opcode == `CARRD_OP_V) && (funct3 == `CARRD_F3_CFG);
    assign is_vx    = funct3 == `CARRD_F3_IVX;
    assign is_alu   = (opcode == `CARRD_OP_V) && op_ok && (is_vx || funct3 == `CARRD_F3_IVV);
    assign is_load  = (opcode == `CARRD_OP_LOAD) && (funct3 == `CARRD_W_E32)
                      && (instr_dat[27:26] == `CARRD_MOP_UNIT);
    assign is_store = (opcode == `CARRD_OP_STORE) && (funct3 == `CARRD_W_E32)
                      && (instr_dat[27:26] == `CARRD_MOP_UNIT);

    // operand reads, store data comes from vs3
    assign rd_addr_a = is_store ? f_vd : f_vs2;
    assign rd_addr_b = f_vs1;

    // tail elements stay untouched
    always_comb begin
        for (int i = 0; i < `CARRD_LANES; i++) begin
            mask_now[i] = i < int'(vl_q);
        end
    end

    ////////////////////
    // stall logic
    assign hazard = (is_alu && (pending_q[f_vs2] || pending_q[f_vd]
                                || (!is_vx && pending_q[f_vs1])))
                    || ((is_load || is_store) && pending_q[f_vd]);
    assign unit_busy = (is_alu && alu_busy) || ((is_load || is_store) && lsu_busy);
    // no new accept while ack of the previous one is out
    assign accept = instr_cyc && instr_stb && !instr_ack && !hazard && !unit_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            instr_ack <= 1'b0;
            alu_start <= 1'b0;
            lsu_start <= 1'b0;
            vl_q      <= vl_t'(`CARRD_LANES);
            pending_q <= '0;
        end else begin
            instr_ack <= accept;
            alu_start <= accept && is_alu;               // start goes out with the ack
            lsu_start <= accept && (is_load || is_store);
            if (accept && is_cfg) begin
                vl_q <= (instr_rs1 > word_t'(`CARRD_LANES)) ? vl_t'(`CARRD_LANES)
                                                            : vl_t'(instr_rs1[2:0]);
            end
            if (wb_valid) pending_q[wb_vd] <= 1'b0;      // retire first
            if (accept && (is_alu || is_load)) pending_q[f_vd] <= 1'b1;
        end
    end

    // dispatch payload
    always_ff @(posedge clk) begin
        if (accept) begin
            alu_op     <= dec_op;
            alu_a      <= rd_data_a;
            alu_b      <= is_vx ? {`CARRD_LANES{instr_rs1}} : rd_data_b;  // scalar broadcast
            alu_vd     <= f_vd;
            lsu_we     <= is_store;
            lsu_base   <= instr_rs1;
            lsu_vl     <= vl_q;
            wb_mask_vl <= mask_now;
        end
    end

    assign lsu_data = alu_a;   // vs3 was read on port a
    assign lsu_vd   = alu_vd;

endmodule

// File: logic/carrd_vregfile.sv
`timescale 1ns/100ps
`include "carrd_params.svh"

module carrd_vregfile
    import carrd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  vaddr_t     rd_addr_a,
    input  vaddr_t     rd_addr_b,
    output vreg_t      rd_data_a,
    output vreg_t      rd_data_b,
    input  logic       wr_en,
    input  vaddr_t     wr_addr,
    input  elem_mask_t wr_mask,
    input  vreg_t      wr_data
);

    vreg_t regs [`CARRD_NREGS];

    // async read ports
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    // element-masked write, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `CARRD_NREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            for (int i = 0; i < `CARRD_LANES; i++) begin
                if (wr_mask[i]) begin
                    regs[wr_addr][i*`CARRD_WORD_W +: `CARRD_WORD_W]
                        <= wr_data[i*`CARRD_WORD_W +: `CARRD_WORD_W];
                end
            end
        end
    end

endmodule

// File: lanes/carrd_vlanes.sv
`timescale 1ns/100ps
`include "carrd_params.svh"

module carrd_vlanes
    import carrd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  alu_op_e    op,
    input  vreg_t      a,
    input  vreg_t      b,
    input  vaddr_t     vd,
    input  elem_mask_t mask,
    output logic       busy,
    output logic       req,
    output vaddr_t     req_vd,
    output vreg_t      req_data,
    output elem_mask_t req_mask,
    input  logic       grant
);

    vreg_t result;
    logic  req_q;

    // one 32-bit lane, add/sub wrap around
    function automatic word_t lane_op(alu_op_e f_op, word_t x, word_t y);
        case (f_op)
            ALU_ADD: lane_op = x + y;
            ALU_SUB: lane_op = x - y;
            ALU_AND: lane_op = x & y;
            ALU_OR:  lane_op = x | y;
            ALU_XOR: lane_op = x ^ y;
            default: lane_op = '0;
        endcase
    endfunction

    for (genvar i = 0; i < `CARRD_LANES; i++) begin : g_lane
        assign result[i*`CARRD_WORD_W +: `CARRD_WORD_W] =
            lane_op(op, a[i*`CARRD_WORD_W +: `CARRD_WORD_W], b[i*`CARRD_WORD_W +: `CARRD_WORD_W]);
    end

    ////////////////////
    // result holding register
    always_ff @(posedge clk) begin
        if (rst) req_q <= 1'b0;
        else if (start) req_q <= 1'b1;      // valid one cycle after start
        else if (grant) req_q <= 1'b0;      // write port taken
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_data <= result;
            req_vd   <= vd;
            req_mask <= mask;
        end
    end

    assign req  = req_q;
    assign busy = req_q;   // no new op until the result is written

endmodule

// File: lsu/carrd_vlsu.sv
`timescale 1ns/100ps
`include "carrd_params.svh"

module carrd_vlsu
    import carrd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       we,
    input  word_t      base,
    input  vl_t        vl,
    input  vreg_t      data,
    input  vaddr_t     vd,
    input  elem_mask_t mask,
    output logic       busy,
    output logic       mem_cyc,
    output logic       mem_stb,
    output logic       mem_we,
    output word_t      mem_adr,
    output word_t      mem_dat_w,
    input  word_t      mem_dat_r,
    input  logic       mem_ack,
    output logic       req,
    output vaddr_t     req_vd,
    output vreg_t      req_data,
    output elem_mask_t req_mask,
    input  logic       grant
);

    lsu_state_e state_q;
    logic       we_q;
    vl_t        vl_q;
    logic [$clog2(`CARRD_LANES)-1:0] beat_q;   // element of the current beat
    logic [`CARRD_ADDR_W-1:0] addr_q;
    vreg_t      stage_q;                       // store data in, load words gathered
    vaddr_t     vd_q;
    elem_mask_t mask_q;
    logic       last_beat;

    assign last_beat = ({1'b0, beat_q} + 3'd1) == vl_q;

    ////////////////////
    // sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= LSU_IDLE;
        end else begin
            case (state_q)
                LSU_IDLE: if (start) begin
                    if (vl != '0) state_q <= LSU_BEAT;
                    else if (!we) state_q <= LSU_WB;   // empty load still retires vd
                end
                LSU_BEAT: if (mem_ack && last_beat) begin
                    state_q <= we_q ? LSU_IDLE : LSU_WB;
                end
                LSU_WB: if (grant) state_q <= LSU_IDLE;
                default: state_q <= LSU_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == LSU_IDLE && start) begin
            we_q    <= we;
            vl_q    <= vl;
            addr_q  <= base;
            beat_q  <= '0;
            stage_q <= data;
            vd_q    <= vd;
            mask_q  <= mask;
        end else if (mem_cyc && mem_ack) begin   // beat done, step on
            if (!we_q) stage_q[beat_q*`CARRD_WORD_W +: `CARRD_WORD_W] <= mem_dat_r;
            beat_q <= beat_q + 1'b1;
            addr_q <= addr_q + `CARRD_ADDR_W'(`CARRD_WORD_W / 8);
        end
    end

    // wishbone master, stb held until the last ack
    assign mem_cyc   = state_q == LSU_BEAT;
    assign mem_stb   = mem_cyc;
    assign mem_we    = mem_cyc && we_q;
    assign mem_adr   = addr_q;
    assign mem_dat_w = stage_q[beat_q*`CARRD_WORD_W +: `CARRD_WORD_W];

    assign busy     = state_q != LSU_IDLE;
    assign req      = state_q == LSU_WB;
    assign req_vd   = vd_q;
    assign req_data = stage_q;
    assign req_mask = mask_q;

endmodule

// File: logic/carrd_wb_arbiter.sv
`timescale 1ns/100ps
`include "carrd_params.svh"

module carrd_wb_arbiter
    import carrd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       alu_req,
    input  vaddr_t     alu_vd,
    input  vreg_t      alu_data,
    input  elem_mask_t alu_mask,
    output logic       alu_grant,
    input  logic       lsu_req,
    input  vaddr_t     lsu_vd,
    input  vreg_t      lsu_data,
    input  elem_mask_t lsu_mask,
    output logic       lsu_grant,
    output logic       wr_en,
    output vaddr_t     wr_addr,
    output elem_mask_t wr_mask,
    output vreg_t      wr_data,
    output logic       wb_valid,
    output vaddr_t     wb_vd
);

    // fixed priority, alu over lsu
    assign alu_grant = alu_req;
    assign lsu_grant = lsu_req && !alu_req;

    always_ff @(posedge clk) begin
        if (rst) wr_en <= 1'b0;
        else wr_en <= alu_req || lsu_req;
    end

    always_ff @(posedge clk) begin
        wr_addr <= alu_req ? alu_vd : lsu_vd;
        wr_mask <= alu_req ? alu_mask : lsu_mask;
        wr_data <= alu_req ? alu_data : lsu_data;
    end

    // same cycle as the regfile write, issue drops pending
    assign wb_valid = wr_en;
    assign wb_vd    = wr_addr;

endmodule

// File: logic/carrd_top.sv
`timescale 1ns/100ps
`include "carrd_params.svh"

module carrd_top
    import carrd_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   instr_cyc,
    input  logic   instr_stb,
    input  instr_t instr_dat,
    input  word_t  instr_rs1,
    output logic   instr_ack,
    output logic   mem_cyc,
    output logic   mem_stb,
    output logic   mem_we,
    output word_t  mem_adr,
    output word_t  mem_dat_w,
    input  word_t  mem_dat_r,
    input  logic   mem_ack
);

    // regfile read side
    vaddr_t     rd_addr_a, rd_addr_b;
    vreg_t      rd_data_a, rd_data_b;
    // dispatch
    logic       alu_start, alu_busy;
    alu_op_e    alu_op;
    vreg_t      alu_a, alu_b;
    vaddr_t     alu_vd;
    logic       lsu_start, lsu_we, lsu_busy;
    word_t      lsu_base;
    vl_t        lsu_vl;
    vreg_t      lsu_data;
    vaddr_t     lsu_vd;
    elem_mask_t wb_mask_vl;
    // writeback requests
    logic       alu_req, alu_grant, lsu_req, lsu_grant;
    vaddr_t     alu_req_vd, lsu_req_vd;
    vreg_t      alu_req_data, lsu_req_data;
    elem_mask_t alu_req_mask, lsu_req_mask;
    // write port
    logic       wr_en, wb_valid;
    vaddr_t     wr_addr, wb_vd;
    elem_mask_t wr_mask;
    vreg_t      wr_data;

    carrd_issue i_issue (
        .clk(clk), .rst(rst),
        .instr_cyc(instr_cyc), .instr_stb(instr_stb),
        .instr_dat(instr_dat), .instr_rs1(instr_rs1), .instr_ack(instr_ack),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .alu_start(alu_start), .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .alu_vd(alu_vd), .alu_busy(alu_busy),
        .lsu_start(lsu_start), .lsu_we(lsu_we), .lsu_base(lsu_base), .lsu_vl(lsu_vl),
        .lsu_data(lsu_data), .lsu_vd(lsu_vd), .lsu_busy(lsu_busy),
        .wb_mask_vl(wb_mask_vl), .wb_valid(wb_valid), .wb_vd(wb_vd)
    );

    carrd_vregfile i_vregfile (
        .clk(clk), .rst(rst),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_mask(wr_mask), .wr_data(wr_data)
    );

    ////////////////////
    // functional units
    carrd_vlanes i_vlanes (
        .clk(clk), .rst(rst),
        .start(alu_start), .op(alu_op), .a(alu_a), .b(alu_b),
        .vd(alu_vd), .mask(wb_mask_vl), .busy(alu_busy),
        .req(alu_req), .req_vd(alu_req_vd), .req_data(alu_req_data),
        .req_mask(alu_req_mask), .grant(alu_grant)
    );

    carrd_vlsu i_vlsu (
        .clk(clk), .rst(rst),
        .start(lsu_start), .we(lsu_we), .base(lsu_base), .vl(lsu_vl),
        .data(lsu_data), .vd(lsu_vd), .mask(wb_mask_vl), .busy(lsu_busy),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
        .mem_dat_w(mem_dat_w), .mem_dat_r(mem_dat_r), .mem_ack(mem_ack),
        .req(lsu_req), .req_vd(lsu_req_vd), .req_data(lsu_req_data),
        .req_mask(lsu_req_mask), .grant(lsu_grant)
    );

    carrd_wb_arbiter i_wb_arbiter (
        .clk(clk), .rst(rst),
        .alu_req(alu_req), .alu_vd(alu_req_vd), .alu_data(alu_req_data),
        .alu_mask(alu_req_mask), .alu_grant(alu_grant),
        .lsu_req(lsu_req), .lsu_vd(lsu_req_vd), .lsu_data(lsu_req_data),
        .lsu_mask(lsu_req_mask), .lsu_grant(lsu_grant),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_mask(wr_mask), .wr_data(wr_data),
        .wb_valid(wb_valid), .wb_vd(wb_vd)
    );

endmodule

// File: tests/carrd_checker.sv
`timescale 1ns/100ps

module carrd_checker
    import carrd_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  instr_stb,
    input logic  instr_ack,
    input logic  mem_cyc,
    input logic  mem_stb,
    input word_t mem_adr
);

    ////////////////////
    // memory master side
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
        mem_stb |-> mem_cyc)
        else $error("mem_stb high outside a mem_cyc cycle");

    // one word per beat, byte address
    a_adr_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_stb |-> (mem_adr[1:0] == 2'b00))
        else $error("mem_adr not word aligned");

    ////////////////////
    // instruction slave side
    a_ack_with_stb: assert property (@(posedge clk) disable iff (rst)
        instr_ack |-> instr_stb)
        else $error("instr_ack without instr_stb");

    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        instr_ack |=> !instr_ack)           // one cycle per instruction
        else $error("instr_ack held for two cycles");

endmodule

// File: tests/carrd_tb.sv
`timescale 1ns/100ps
`include "carrd_params.svh"

module carrd_tb
    import carrd_pkg::*;
();

    logic   clk, rst;
    logic   instr_cyc, instr_stb, instr_ack;
    instr_t instr_dat;
    word_t  instr_rs1;
    logic   mem_cyc, mem_stb, mem_we, mem_ack;
    word_t  mem_adr, mem_dat_w, mem_dat_r;

    word_t mem [256];                        // 1 KB word array seen by the dut
    word_t ref_mem [256];                    // model copy
    word_t ref_v [`CARRD_NREGS][`CARRD_LANES];
    int    ref_vl;
    word_t exp_adr [$];                      // store beats still to come
    word_t exp_dat [$];
    int    n_errors, n_checks, n_issued, cycle_cnt;

    carrd_top i_carrd_top (
        .clk(clk), .rst(rst),
        .instr_cyc(instr_cyc), .instr_stb(instr_stb), .instr_dat(instr_dat),
        .instr_rs1(instr_rs1), .instr_ack(instr_ack),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we), .mem_adr(mem_adr),
        .mem_dat_w(mem_dat_w), .mem_dat_r(mem_dat_r), .mem_ack(mem_ack)
    );

    bind carrd_top carrd_checker i_checker (
        .clk(clk), .rst(rst), .instr_stb(instr_stb), .instr_ack(instr_ack),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_adr(mem_adr)
    );

    always #5 clk = ~clk;

    // hang guard at 40 cycles per instruction
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > 40 * (n_issued + 2)) begin
            $display("timeout: no progress after %0d cycles, %0d instructions issued",
                     cycle_cnt, n_issued);
            $display("checks=%0d errors=%0d", n_checks, n_errors + 1);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////
    // memory model
    task automatic check_write();
        word_t a, d;
        n_checks++;
        assert (exp_adr.size() > 0) else begin
            $display("unexpected store beat at time %0t to address %h", $time, mem_adr);
            n_errors++;
        end
        if (exp_adr.size() > 0) begin
            a = exp_adr.pop_front();
            d = exp_dat.pop_front();
            assert (mem_adr == a) else begin
                $display("ERROR t=%0t mem_adr got %h expected %h", $time, mem_adr, a);
                n_errors++;
            end
            assert (mem_dat_w == d) else begin
                $display("ERROR t=%0t mem_dat_w got %h expected %h", $time, mem_dat_w, d);
                n_errors++;
            end
        end
        mem[mem_adr[9:2]] = mem_dat_w;
    endtask

    task automatic serve_mem();
        int unsigned lag;
        forever begin
            @(posedge clk);
            #1;
            mem_ack = 1'b0;
            if (mem_cyc && mem_stb) begin
                lag = $urandom % 4;              // back-pressure 0..3 cycles
                repeat (lag) begin
                    @(posedge clk);
                    #1;
                end
                if (mem_we) check_write();
                else mem_dat_r = mem[mem_adr[9:2]];
                mem_ack = 1'b1;
            end
        end
    endtask

    ////////////////////
    // host side and reference model
    task automatic send(input instr_t ins, input word_t rs1);
        instr_cyc = 1'b1;
        instr_stb = 1'b1;
        instr_dat = ins;
        instr_rs1 = rs1;
        n_issued++;
        do begin
            @(posedge clk);
            #1;
        end while (!instr_ack);
        @(posedge clk);                          // stb stays up across the ack edge
        #1;
        instr_cyc = 1'b0;
        instr_stb = 1'b0;
    endtask

    function automatic word_t ref_alu(logic [5:0] f6, word_t x, word_t y);
        case (f6)
            `CARRD_F6_VADD: return x + y;        // wraps at 32 bits
            `CARRD_F6_VSUB: return x - y;        // vs2 minus vs1 or rs1
            `CARRD_F6_VAND: return x & y;
            `CARRD_F6_VOR:  return x | y;
            default:        return x ^ y;
        endcase
    endfunction

    function automatic logic [5:0] pick_op(int unsigned k);
        case (k)
            0:       return `CARRD_F6_VADD;
            1:       return `CARRD_F6_VSUB;
            2:       return `CARRD_F6_VAND;
            3:       return `CARRD_F6_VOR;
            default: return `CARRD_F6_VXOR;
        endcase
    endfunction

    task automatic set_vl(input word_t avl);
        send({1'b0, 11'h010, 5'd1, `CARRD_F3_CFG, 5'd0, `CARRD_OP_V}, avl);
        ref_vl = (avl > 4) ? 4 : int'(avl);
    endtask

    task automatic arith(input logic [5:0] f6, input logic vx, input int vd, vs2, vs1,
                         input word_t rs1);
        send({f6, 1'b1, 5'(vs2), 5'(vs1), (vx ? `CARRD_F3_IVX : `CARRD_F3_IVV), 5'(vd),
              `CARRD_OP_V}, rs1);
        for (int i = 0; i < ref_vl; i++) begin
            ref_v[vd][i] = ref_alu(f6, ref_v[vs2][i], vx ? rs1 : ref_v[vs1][i]);
        end
    endtask

    task automatic load_vec(input int vd, input word_t base);
        send({3'b000, 1'b0, `CARRD_MOP_UNIT, 1'b1, 5'd0, 5'd1, `CARRD_W_E32, 5'(vd),
              `CARRD_OP_LOAD}, base);
        for (int i = 0; i < ref_vl; i++) begin
            ref_v[vd][i] = ref_mem[base[9:2] + i];
        end
    endtask

    task automatic store_vec(input int vs3, input word_t base);
        for (int i = 0; i < ref_vl; i++) begin  // queue beats before they can start
            exp_adr.push_back(base + 4 * i);
            exp_dat.push_back(ref_v[vs3][i]);
            ref_mem[base[9:2] + i] = ref_v[vs3][i];
        end
        send({3'b000, 1'b0, `CARRD_MOP_UNIT, 1'b1, 5'd0, 5'd1, `CARRD_W_E32, 5'(vs3),
              `CARRD_OP_STORE}, base);
    endtask

    ////////////////////
    // stimulus
    initial begin
        word_t s;
        void'($urandom(31930));
        clk       = 1'b0;
        rst       = 1'b1;
        instr_cyc = 1'b0;
        instr_stb = 1'b0;
        instr_dat = '0;
        instr_rs1 = '0;
        mem_ack   = 1'b0;
        mem_dat_r = '0;
        n_errors  = 0;
        n_checks  = 0;
        n_issued  = 0;
        cycle_cnt = 0;
        ref_vl    = 4;
        for (int i = 0; i < 256; i++) begin
            mem[i]     = (word_t'(i) * 32'h9e37_79b9) ^ 32'h0f0f_3c3c;
            ref_mem[i] = mem[i];
        end
        for (int r = 0; r < `CARRD_NREGS; r++) begin
            for (int e = 0; e < `CARRD_LANES; e++) begin
                ref_v[r][e] = '0;
            end
        end
        fork
            serve_mem();
        join_none
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        load_vec(1, 32'h000);                    // copy four words
        store_vec(1, 32'h100);
        load_vec(2, 32'h010);
        for (int k = 0; k < 5; k++) begin        // vector-vector ops
            arith(pick_op(k), 1'b0, 3 + k, 1, 2, '0);
        end
        for (int k = 0; k < 5; k++) begin
            store_vec(3 + k, 32'h200 + 16 * k);
        end
        arith(`CARRD_F6_VADD, 1'b1, 8, 1, 0, 32'h1234_5678);   // scalar broadcast
        arith(`CARRD_F6_VXOR, 1'b1, 9, 2, 0, $urandom);
        store_vec(8, 32'h280);
        store_vec(9, 32'h290);
        send({6'b100101, 1'b1, 5'd1, 5'd2, `CARRD_F3_IVV, 5'd4, `CARRD_OP_V}, '0);
        store_vec(4, 32'h2a0);                   // v4 untouched by the dropped op

        set_vl(2);                               // beat counts follow vl
        store_vec(1, 32'h300);
        set_vl(9);
        store_vec(1, 32'h310);
        set_vl(0);
        store_vec(1, 32'h320);

        set_vl(4);                               // tail undisturbed
        load_vec(10, 32'h020);
        arith(`CARRD_F6_VADD, 1'b0, 11, 1, 2, '0);
        set_vl(2);
        load_vec(10, 32'h040);
        arith(`CARRD_F6_VXOR, 1'b0, 11, 1, 2, '0);
        set_vl(4);
        store_vec(10, 32'h330);
        store_vec(11, 32'h340);

        load_vec(12, 32'h080);                   // overlap then a dependent op
        arith(`CARRD_F6_VADD, 1'b0, 13, 1, 2, '0);
        arith(`CARRD_F6_VSUB, 1'b0, 14, 12, 13, '0);
        store_vec(14, 32'h350);
        store_vec(13, 32'h360);

        for (int n = 0; n < 8; n++) begin        // random mix
            s = ($urandom % 252) * 4;
            load_vec(16 + n % 4, s);
            arith(pick_op($urandom % 5), 1'($urandom % 2), 20 + n % 4, 16 + n % 4,
                  1 + n % 2, $urandom);
            store_vec(20 + n % 4, ($urandom % 252) * 4);
        end

        while (exp_adr.size() != 0 || mem_cyc) begin
            @(posedge clk);
            #1;
        end
        repeat (5) @(posedge clk);
        $display("checks=%0d errors=%0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: carrd.f
+incdir+common
common/carrd_pkg.sv
logic/carrd_issue.sv
logic/carrd_vregfile.sv
lanes/carrd_vlanes.sv
lsu/carrd_vlsu.sv
logic/carrd_wb_arbiter.sv
logic/carrd_top.sv
tests/carrd_checker.sv
tests/carrd_tb.sv

// File: Makefile
# Verilator build and run of the carrd testbench

VERILATOR ?= verilator
TOP       ?= carrd_tb
FILELIST  ?= carrd.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
